//--- hw/sf_pkg.sv
/* shared widths, access size, store/load/flush structs
   and the byte mask helper for the speculative-fail path */
package sf_pkg;

  // physical address and instruction id
  localparam int unsigned SF_PA_WIDTH   = 40;
  localparam int unsigned SF_LINE_WIDTH = SF_PA_WIDTH - 4;
  // top bit is the wrap bit
  localparam int unsigned SF_IID_WIDTH  = 7;

  typedef enum logic [1:0] {
    SF_SIZE_BYTE   = 2'd0,
    SF_SIZE_HALF   = 2'd1,
    SF_SIZE_WORD   = 2'd2,
    SF_SIZE_DOUBLE = 2'd3
  } sf_size_e;

  // ============================
  // pipeline structs
  // ============================
  // store from address stage
  typedef struct packed {
    logic                    valid;
    logic [SF_PA_WIDTH-1:0]  addr;
    sf_size_e                size;
    logic [SF_IID_WIDTH-1:0] iid;
    logic                    no_spec_miss;
    logic                    spec_chk;
  } sf_st_req_t;

  // store in data-access stage, flags already qualified
  typedef struct packed {
    logic [SF_LINE_WIDTH-1:0] tag;
    logic [15:0]              bytes_vld;
    logic [SF_IID_WIDTH-1:0]  iid;
    logic                     no_spec_miss;
    logic                     spec_chk;
  } sf_st_da_t;

  // load from address stage
  typedef struct packed {
    logic                   valid;
    logic [SF_PA_WIDTH-1:0] addr;
    sf_size_e               size;
  } sf_ld_req_t;

  // load in data-access stage
  typedef struct packed {
    logic                     chk_req;
    logic [SF_LINE_WIDTH-1:0] tag;
    logic [15:0]              bytes_vld;
  } sf_ld_da_t;

  // retire flush, one cycle pulse
  typedef struct packed {
    logic                    flush;
    logic                    spec_fail_flush;
    logic [SF_IID_WIDTH-1:0] spec_fail_iid;
  } sf_flush_t;

  // contiguous run of 1/2/4/8 bytes from offset, cut at byte 15
  function automatic logic [15:0] sf_byte_mask(input logic [3:0] offset, input sf_size_e size);
    logic [15:0] run;
    case (size)
      SF_SIZE_BYTE: run = 16'h0001;
      SF_SIZE_HALF: run = 16'h0003;
      SF_SIZE_WORD: run = 16'h000f;
      default:      run = 16'h00ff;
    endcase
    // bits shifted past 15 fall off
    return run << offset;
  endfunction

endpackage

//--- hw/sf_clk_gate.sv
/* latch-based clock gate with module enable and scan override */
`timescale 1ns/1ps

module sf_clk_gate (
  input  logic clk_in,
  input  logic local_en,
  input  logic module_en,
  input  logic scan_en,
  output logic clk_out
);

  logic gate_en;
  logic en_lat;

  // module_en forces the gate open, as does scan
  assign gate_en = local_en | module_en | scan_en;

  // transparent while clock low, no glitch on high phase
  always_latch
  begin
    if (!clk_in)
      en_lat = gate_en;
  end

  assign clk_out = clk_in & en_lat;

endmodule

//--- hw/sf_iid_age_cmp.sv
/* instruction id age compare with wrap bit */
`timescale 1ns/1ps

module sf_iid_age_cmp
  import sf_pkg::*;
(
  input  logic [SF_IID_WIDTH-1:0] iid0,
  input  logic [SF_IID_WIDTH-1:0] iid1,
  output logic                    iid0_older
);

  logic same_wrap;

  assign same_wrap = (iid0[SF_IID_WIDTH-1] == iid1[SF_IID_WIDTH-1]);

  // same lap: smaller id is older
  // different lap: iid0 wrapped earlier when its low bits are larger
  assign iid0_older = same_wrap ? (iid0[SF_IID_WIDTH-2:0] < iid1[SF_IID_WIDTH-2:0])
                                : (iid0[SF_IID_WIDTH-2:0] > iid1[SF_IID_WIDTH-2:0]);

endmodule

//--- hw/sf_st_da_stage.sv
/* store data-access stage register, byte mask build
   and no_spec_miss / spec_chk qualification */
`timescale 1ns/1ps

module sf_st_da_stage
  import sf_pkg::*;
(
  input  logic       sf_clk,
  input  logic       cpurst_b,
  input  sf_st_req_t st_req,
  input  logic       flush,
  output sf_st_da_t  st_da
);

  logic                     no_spec_miss_q;
  logic                     spec_chk_q;
  logic [SF_LINE_WIDTH-1:0] tag_q;
  logic [15:0]              bytes_q;
  logic [SF_IID_WIDTH-1:0]  iid_q;

  // ============================
  // flags, cleared by flush
  // ============================
  always_ff @(posedge sf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      no_spec_miss_q <= 1'b0;
      spec_chk_q     <= 1'b0;
    end
    else if (flush)
    begin
      no_spec_miss_q <= 1'b0;
      spec_chk_q     <= 1'b0;
    end
    else
    begin
      // only a valid store carries its flags forward
      no_spec_miss_q <= st_req.valid & st_req.no_spec_miss;
      spec_chk_q     <= st_req.valid & st_req.spec_chk;
    end
  end

  // payload, loaded only for a valid store
  always_ff @(posedge sf_clk)
  begin
    if (st_req.valid)
    begin
      tag_q   <= st_req.addr[SF_PA_WIDTH-1:4];
      bytes_q <= sf_byte_mask(st_req.addr[3:0], st_req.size);
      iid_q   <= st_req.iid;
    end
  end

  assign st_da.tag          = tag_q;
  assign st_da.bytes_vld    = bytes_q;
  assign st_da.iid          = iid_q;
  assign st_da.no_spec_miss = no_spec_miss_q;
  assign st_da.spec_chk     = spec_chk_q;

  // a registered store always covers at least one byte
  a_st_mask_nonzero: assert property (
    @(posedge sf_clk) disable iff (!cpurst_b)
    st_req.valid |=> (st_da.bytes_vld != 16'h0000)
  );

endmodule

//--- hw/sf_ld_da_stage.sv
/* load data-access stage register, byte mask build
   and check request toward the predictor */
`timescale 1ns/1ps

module sf_ld_da_stage
  import sf_pkg::*;
(
  input  logic       sf_clk,
  input  logic       cpurst_b,
  input  sf_ld_req_t ld_req,
  input  logic       flush,
  output sf_ld_da_t  ld_da
);

  logic                     chk_req_q;
  logic [SF_LINE_WIDTH-1:0] tag_q;
  logic [15:0]              bytes_q;

  // ============================
  // check request
  // ============================
  always_ff @(posedge sf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      chk_req_q <= 1'b0;
    else if (flush)
      chk_req_q <= 1'b0;
    else
      // every valid load checks the trackers
      chk_req_q <= ld_req.valid;
  end

  // line tag and bytes, held when no load
  always_ff @(posedge sf_clk)
  begin
    if (ld_req.valid)
    begin
      tag_q   <= ld_req.addr[SF_PA_WIDTH-1:4];
      bytes_q <= sf_byte_mask(ld_req.addr[3:0], ld_req.size);
    end
  end

  assign ld_da.chk_req   = chk_req_q;
  assign ld_da.tag       = tag_q;
  assign ld_da.bytes_vld = bytes_q;

  // a checking load always covers at least one byte
  a_ld_chk_mask: assert property (
    @(posedge sf_clk) disable iff (!cpurst_b)
    ld_da.chk_req |-> (ld_da.bytes_vld != 16'h0000)
  );

endmodule

//--- hw/sf_spec_fail_predict.sv
/* speculative-fail prediction start tracker and misprediction
   check tracker, with gated clocks and age-out counters */
`timescale 1ns/1ps

module sf_spec_fail_predict
  import sf_pkg::*;
#(
  parameter int unsigned CLR_LIMIT = 12
)
(
  input  logic      sf_clk,
  input  logic      cpurst_b,
  input  logic      icg_en,
  input  logic      scan_en,
  input  sf_st_da_t st_da,
  input  sf_ld_da_t ld_da,
  input  sf_flush_t flush,
  output logic      sf_spec_mark,
  output logic      sf_spec_hit
);

  localparam int unsigned CNT_W = $clog2(CLR_LIMIT + 1);

  // gated clocks
  logic ctrl_clk_en;
  logic ctrl_clk;
  logic start_dp_clk;
  logic chk_dp_clk;

  // start tracker
  logic                     start_pre;
  logic                     start_vld;
  logic [CNT_W-1:0]         start_cnt;
  logic [SF_LINE_WIDTH-1:0] start_tag;
  logic [15:0]              start_bytes;
  logic [SF_IID_WIDTH-1:0]  start_iid;
  logic                     start_st_older;
  logic                     start_info_up;
  logic                     start_success;
  logic                     start_cnt_max;
  logic                     ld_hit_start;

  // check tracker
  logic                     chk_vld;
  logic [CNT_W-1:0]         chk_cnt;
  logic [SF_LINE_WIDTH-1:0] chk_tag;
  logic [15:0]              chk_bytes;
  logic [SF_IID_WIDTH-1:0]  chk_iid;
  logic                     chk_st_older;
  logic                     chk_info_up;
  logic                     chk_cnt_max;
  logic                     ld_hit_chk;

  // ============================
  // clock gating
  // ============================
  // control clock runs while anything is live or may change
  assign ctrl_clk_en = start_pre | start_vld | chk_vld
                     | st_da.no_spec_miss | st_da.spec_chk | flush.flush;

  sf_clk_gate u_ctrl_gate (
    .clk_in    (sf_clk),
    .local_en  (ctrl_clk_en),
    .module_en (icg_en),
    .scan_en   (scan_en),
    .clk_out   (ctrl_clk)
  );

  // start entry data, only when a candidate store shows up
  sf_clk_gate u_start_dp_gate (
    .clk_in    (sf_clk),
    .local_en  (st_da.no_spec_miss),
    .module_en (icg_en),
    .scan_en   (scan_en),
    .clk_out   (start_dp_clk)
  );

  // check entry data
  sf_clk_gate u_chk_dp_gate (
    .clk_in    (sf_clk),
    .local_en  (st_da.spec_chk),
    .module_en (icg_en),
    .scan_en   (scan_en),
    .clk_out   (chk_dp_clk)
  );

  // ============================
  // prediction start
  // ============================
  // incoming store older than the pending one
  sf_iid_age_cmp u_start_age (
    .iid0       (st_da.iid),
    .iid1       (start_iid),
    .iid0_older (start_st_older)
  );

  assign start_info_up = st_da.no_spec_miss & ~start_vld & (~start_pre | start_st_older);

  // retire flushed on the pending store's id
  assign start_success = start_pre & flush.flush & flush.spec_fail_flush
                       & (flush.spec_fail_iid == start_iid);

  assign start_cnt_max = (start_cnt == CNT_W'(CLR_LIMIT));

  // younger load on same line with shared bytes
  assign ld_hit_start = start_vld & ld_da.chk_req & (ld_da.tag == start_tag)
                      & (|(ld_da.bytes_vld & start_bytes));

  always_ff @(posedge ctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      start_pre <= 1'b0;
    else if (flush.flush)
      start_pre <= 1'b0;
    else if (start_info_up)
      start_pre <= 1'b1;
  end

  // arming wins, since it comes with a flush
  always_ff @(posedge ctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      start_vld <= 1'b0;
    else if (start_success)
      start_vld <= 1'b1;
    else if (ld_hit_start | start_cnt_max | flush.flush)
      start_vld <= 1'b0;
  end

  // counts load checks while armed, holds at limit
  always_ff @(posedge ctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      start_cnt <= '0;
    else if (start_success)
      start_cnt <= '0;
    else if (start_vld & ld_da.chk_req & ~start_cnt_max)
      start_cnt <= start_cnt + 1'b1;
  end

  always_ff @(posedge start_dp_clk)
  begin
    if (start_info_up)
    begin
      start_tag   <= st_da.tag;
      start_bytes <= st_da.bytes_vld;
      start_iid   <= st_da.iid;
    end
  end

  assign sf_spec_mark = ld_hit_start;

  // ============================
  // misprediction check
  // ============================
  sf_iid_age_cmp u_chk_age (
    .iid0       (st_da.iid),
    .iid1       (chk_iid),
    .iid0_older (chk_st_older)
  );

  // empty, or replaced by an older store
  assign chk_info_up = st_da.spec_chk & (~chk_vld | chk_st_older);

  assign chk_cnt_max = (chk_cnt == CNT_W'(CLR_LIMIT));

  assign ld_hit_chk = chk_vld & ld_da.chk_req & (ld_da.tag == chk_tag)
                    & (|(ld_da.bytes_vld & chk_bytes));

  always_ff @(posedge ctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      chk_vld <= 1'b0;
    else if (flush.flush)
      chk_vld <= 1'b0;
    else if (chk_info_up)
      chk_vld <= 1'b1;
    else if (ld_hit_chk | chk_cnt_max)
      chk_vld <= 1'b0;
  end

  // restarts on every capture
  always_ff @(posedge ctrl_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      chk_cnt <= '0;
    else if (chk_info_up)
      chk_cnt <= '0;
    else if (chk_vld & ld_da.chk_req & ~chk_cnt_max)
      chk_cnt <= chk_cnt + 1'b1;
  end

  always_ff @(posedge chk_dp_clk)
  begin
    if (chk_info_up)
    begin
      chk_tag   <= st_da.tag;
      chk_bytes <= st_da.bytes_vld;
      chk_iid   <= st_da.iid;
    end
  end

  assign sf_spec_hit = ld_hit_chk;

  // ============================
  // checks
  // ============================
  // a mark needs an armed entry, and the marking load consumes it
  a_mark_clears: assert property (
    @(posedge sf_clk) disable iff (!cpurst_b)
    sf_spec_mark |-> start_vld ##1 !start_vld
  );

  a_cnt_limit: assert property (
    @(posedge sf_clk) disable iff (!cpurst_b)
    (start_cnt <= CNT_W'(CLR_LIMIT)) && (chk_cnt <= CNT_W'(CLR_LIMIT))
  );

endmodule

//--- hw/sf_lsu_top.sv
/* store and load data-access stages feeding the
   speculative-fail predictor */
`timescale 1ns/1ps

module sf_lsu_top
  import sf_pkg::*;
#(
  parameter int unsigned CLR_LIMIT = 12
)
(
  input  logic       sf_clk,
  input  logic       cpurst_b,
  input  logic       icg_en,
  input  logic       scan_en,
  input  sf_st_req_t st_req,
  input  sf_ld_req_t ld_req,
  input  sf_flush_t  rtu_flush,
  output logic       sf_spec_mark,
  output logic       sf_spec_hit
);

  sf_st_da_t st_da;
  sf_ld_da_t ld_da;

  // plain flush empties both stages
  sf_st_da_stage u_st_da (
    .sf_clk   (sf_clk),
    .cpurst_b (cpurst_b),
    .st_req   (st_req),
    .flush    (rtu_flush.flush),
    .st_da    (st_da)
  );

  sf_ld_da_stage u_ld_da (
    .sf_clk   (sf_clk),
    .cpurst_b (cpurst_b),
    .ld_req   (ld_req),
    .flush    (rtu_flush.flush),
    .ld_da    (ld_da)
  );

  sf_spec_fail_predict #(
    .CLR_LIMIT (CLR_LIMIT)
  ) u_predict (
    .sf_clk       (sf_clk),
    .cpurst_b     (cpurst_b),
    .icg_en       (icg_en),
    .scan_en      (scan_en),
    .st_da        (st_da),
    .ld_da        (ld_da),
    .flush        (rtu_flush),
    .sf_spec_mark (sf_spec_mark),
    .sf_spec_hit  (sf_spec_hit)
  );

endmodule

//--- tests/tb_sf_table.svh
/* stimulus rows with expected mark and hit per cycle */
`ifndef TB_SF_TABLE_SVH
`define TB_SF_TABLE_SVH

  // one row per cycle, outputs checked late in that same cycle
  // so a load shows its result in the row after it
  typedef struct {
    sf_st_req_t st;
    sf_ld_req_t ld;
    sf_flush_t  fl;
    logic       mark;
    logic       hit;
  } row_t;

  row_t tbl[$];

  task automatic build_table();
    // ============================
    // after reset, nothing tracked
    // ============================
    add_row(no_store(), load_rnd(), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h1000, SF_SIZE_WORD), no_flush(), 0, 0);
    // ============================
    // prediction flow on line 0x100
    // ============================
    // bytes 4..7, iid 10
    add_row(store_op(40'h1004, SF_SIZE_WORD, 7'd10, 1, 0), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), spec_flush(7'd10), 0, 0);
    add_row(no_store(), load_op(40'h1006, SF_SIZE_HALF), no_flush(), 0, 0);
    // first load marked, entry consumed
    add_row(no_store(), load_op(40'h1006, SF_SIZE_HALF), no_flush(), 1, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    // ============================
    // iid, line and byte qualification
    // ============================
    add_row(store_op(40'h2008, SF_SIZE_DOUBLE, 7'd20, 1, 0), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    // wrong iid, pending entry dropped unarmed
    add_row(no_store(), no_load(), spec_flush(7'd21), 0, 0);
    add_row(no_store(), load_op(40'h2008, SF_SIZE_BYTE), no_flush(), 0, 0);
    add_row(store_op(40'h2008, SF_SIZE_DOUBLE, 7'd22, 1, 0), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), spec_flush(7'd22), 0, 0);
    // same line disjoint bytes, then other line
    add_row(no_store(), load_op(40'h2000, SF_SIZE_DOUBLE), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h3008, SF_SIZE_DOUBLE), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h200c, SF_SIZE_WORD), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 1, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    // ============================
    // misprediction check on line 0x400
    // ============================
    add_row(store_op(40'h4000, SF_SIZE_WORD, 7'd40, 0, 1), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h4002, SF_SIZE_HALF), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h4002, SF_SIZE_HALF), no_flush(), 0, 1);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    // iid 45 is older than 50 and takes the entry
    add_row(store_op(40'h4000, SF_SIZE_WORD, 7'd50, 0, 1), no_load(), no_flush(), 0, 0);
    add_row(store_op(40'h4008, SF_SIZE_DOUBLE, 7'd45, 0, 1), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h4000, SF_SIZE_WORD), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h400c, SF_SIZE_WORD), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 1);
    // ============================
    // aging and plain flush
    // ============================
    add_row(store_op(40'h5000, SF_SIZE_WORD, 7'd60, 1, 0), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), spec_flush(7'd60), 0, 0);
    // load checks on unrelated lines run the counter out
    repeat (CLR_LIMIT) add_row(no_store(), load_rnd(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), load_op(40'h5000, SF_SIZE_BYTE), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(store_op(40'h6000, SF_SIZE_WORD, 7'd70, 0, 1), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), plain_flush(), 0, 0);
    add_row(no_store(), load_op(40'h6000, SF_SIZE_WORD), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
    add_row(no_store(), no_load(), no_flush(), 0, 0);
  endtask

`endif

//--- tests/tb_sf_lsu_top.sv
/* testbench for the speculative-fail LSU top: clock, reset,
   table-driven stimulus, output checks and timeout */
`timescale 1ns/1ps

module tb_sf_lsu_top
  import sf_pkg::*;
();

  localparam int CLK_HALF   = 20;
  localparam int RST_CYCLES = 8;
  localparam int CLR_LIMIT  = 12;

  logic       sf_clk;
  logic       cpurst_b;
  logic       icg_en;
  logic       scan_en;
  sf_st_req_t st_req;
  sf_ld_req_t ld_req;
  sf_flush_t  rtu_flush;
  logic       sf_spec_mark;
  logic       sf_spec_hit;

  integer seed;
  int     cycle_cnt;
  int     cycle_limit;

  sf_lsu_top #(
    .CLR_LIMIT (CLR_LIMIT)
  ) u_sf_lsu_top (
    .sf_clk       (sf_clk),
    .cpurst_b     (cpurst_b),
    .icg_en       (icg_en),
    .scan_en      (scan_en),
    .st_req       (st_req),
    .ld_req       (ld_req),
    .rtu_flush    (rtu_flush),
    .sf_spec_mark (sf_spec_mark),
    .sf_spec_hit  (sf_spec_hit)
  );

  // 40 ns period
  always #CLK_HALF sf_clk = ~sf_clk;

  // ============================
  // row builders
  // ============================
  function automatic sf_st_req_t store_op(input logic [SF_PA_WIDTH-1:0] addr,
                                          input sf_size_e size,
                                          input logic [SF_IID_WIDTH-1:0] iid,
                                          input logic nsm, input logic chk);
    sf_st_req_t s;
    s.valid        = 1'b1;
    s.addr         = addr;
    s.size         = size;
    s.iid          = iid;
    s.no_spec_miss = nsm;
    s.spec_chk     = chk;
    return s;
  endfunction

  function automatic sf_st_req_t no_store();
    return '0;
  endfunction

  function automatic sf_ld_req_t load_op(input logic [SF_PA_WIDTH-1:0] addr,
                                         input sf_size_e size);
    sf_ld_req_t l;
    l.valid = 1'b1;
    l.addr  = addr;
    l.size  = size;
    return l;
  endfunction

  function automatic sf_ld_req_t no_load();
    return '0;
  endfunction

  // top byte 0x5a keeps it off every tracked line
  function automatic sf_ld_req_t load_rnd();
    logic [31:0] r;
    sf_ld_req_t  l;
    r       = $random(seed);
    l.valid = 1'b1;
    l.addr  = {8'h5a, r};
    l.size  = sf_size_e'(r[5:4]);
    return l;
  endfunction

  function automatic sf_flush_t no_flush();
    return '0;
  endfunction

  function automatic sf_flush_t plain_flush();
    sf_flush_t f;
    f               = '0;
    f.flush         = 1'b1;
    return f;
  endfunction

  function automatic sf_flush_t spec_flush(input logic [SF_IID_WIDTH-1:0] iid);
    sf_flush_t f;
    f.flush           = 1'b1;
    f.spec_fail_flush = 1'b1;
    f.spec_fail_iid   = iid;
    return f;
  endfunction

  `include "tb_sf_table.svh"

  task automatic add_row(input sf_st_req_t st, input sf_ld_req_t ld, input sf_flush_t fl,
                         input logic mark, input logic hit);
    row_t r;
    r.st   = st;
    r.ld   = ld;
    r.fl   = fl;
    r.mark = mark;
    r.hit  = hit;
    tbl.push_back(r);
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // ============================
  // run guard
  // ============================
  always @(posedge sf_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("timeout: table did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  initial
  begin
    sf_clk    = 1'b0;
    cpurst_b  = 1'b0;
    icg_en    = 1'b0;
    scan_en   = 1'b0;
    st_req    = '0;
    ld_req    = '0;
    rtu_flush = '0;
    cycle_cnt = 0;
    seed      = 26;
    build_table();
    cycle_limit = tbl.size() + RST_CYCLES + 20;
    repeat (RST_CYCLES) @(posedge sf_clk);
    #1;
    cpurst_b = 1'b1;
    for (int i = 0; i < tbl.size(); i++)
    begin
      @(posedge sf_clk);
      #1;
      st_req    = tbl[i].st;
      ld_req    = tbl[i].ld;
      rtu_flush = tbl[i].fl;
      // sample just before the next rising edge
      #(2 * CLK_HALF - 2);
      check_val(sf_spec_mark, tbl[i].mark, $sformatf("row %0d mark", i));
      check_val(sf_spec_hit, tbl[i].hit, $sformatf("row %0d hit", i));
    end
    @(posedge sf_clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+tests
hw/sf_pkg.sv
hw/sf_clk_gate.sv
hw/sf_iid_age_cmp.sv
hw/sf_st_da_stage.sv
hw/sf_ld_da_stage.sv
hw/sf_spec_fail_predict.sv
hw/sf_lsu_top.sv
tests/tb_sf_lsu_top.sv

//--- Bender.yml
package:
  name: sf_lsu

sources:
  - files:
      - hw/sf_pkg.sv
      - hw/sf_clk_gate.sv
      - hw/sf_iid_age_cmp.sv
      - hw/sf_st_da_stage.sv
      - hw/sf_ld_da_stage.sv
      - hw/sf_spec_fail_predict.sv
      - hw/sf_lsu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_sf_lsu_top.sv
